// ==== src.f ====
rtl/apb_soc_pkg.sv
rtl/apb_node.sv
rtl/gpio_regs.sv
rtl/adv_timer.sv
rtl/soc_ctrl_regs.sv
rtl/periph_bus_wrap.sv
sim/tb_checker.sv
sim/tb_periph_asserts.sv
sim/tb_periph_bus.sv

// ==== Bender.yml ====
package:
  name: periph_bus

sources:
  - rtl/apb_soc_pkg.sv
  - rtl/apb_node.sv
  - rtl/gpio_regs.sv
  - rtl/adv_timer.sv
  - rtl/soc_ctrl_regs.sv
  - rtl/periph_bus_wrap.sv
  - target: simulation
    files:
      - sim/tb_checker.sv
      - sim/tb_periph_asserts.sv
      - sim/tb_periph_bus.sv

// ==== sim/tb_periph_bus.sv ====
// peripheral bus testbench
`default_nettype none

module tb_periph_bus
    import apb_soc_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned NUM_GPIO       = 16;
    localparam int unsigned CLK_PERIOD     = 10;
    localparam int unsigned RESET_CYCLES   = 8;
    localparam int unsigned NUM_XFERS      = 2000;
    localparam int unsigned DIRECTED_XFERS = 20;
    localparam int unsigned IRQ_WAIT       = 20;
    localparam int unsigned MAX_XFER_CYC   = 6;
    localparam int unsigned TIMEOUT_NS     = (RESET_CYCLES + IRQ_WAIT
        + (NUM_XFERS + DIRECTED_XFERS) * MAX_XFER_CYC) * CLK_PERIOD;
    localparam logic [31:0] TMR = ADVTIMER_BASE;

    logic                clk = 1'b0;
    logic                arst_n;
    apb_req_t            req;
    apb_rsp_t            rsp;
    logic [NUM_GPIO-1:0] gpio_in;
    logic [NUM_GPIO-1:0] gpio_out;
    logic [NUM_GPIO-1:0] gpio_oe;
    logic                timer_irq;
    logic [31:0]         boot_addr;
    int unsigned         err_count;
    int unsigned         check_count;
    int unsigned         assert_fails;

    // every defined offset plus a few holes and addresses outside the map
    logic [31:0] addr_list [17] = '{
        GPIO_BASE, GPIO_BASE + 32'h4, GPIO_BASE + 32'h8, GPIO_BASE + 32'hC,
        TMR, TMR + 32'h4, TMR + 32'h8, TMR + 32'hC,
        SOCCTRL_BASE, SOCCTRL_BASE + 32'h4, SOCCTRL_BASE + 32'h8, SOCCTRL_BASE + 32'hC,
        32'h0000_0000, 32'h1A10_0FFC, 32'h1A10_3000, 32'h1A10_5000, 32'hFFFF_FFFC
    };

    always #(CLK_PERIOD / 2) clk = ~clk;

    periph_bus_wrap i_periph_bus_wrap (
        .clk_i     ( clk       ),
        .arst_n    ( arst_n    ),
        .req       ( req       ),
        .rsp       ( rsp       ),
        .gpio_in   ( gpio_in   ),
        .gpio_out  ( gpio_out  ),
        .gpio_oe   ( gpio_oe   ),
        .timer_irq ( timer_irq ),
        .boot_addr ( boot_addr )
    );

    tb_checker #(
        .NUM_GPIO ( NUM_GPIO )
    ) i_tb_checker (
        .clk_i       ( clk         ),
        .arst_n      ( arst_n      ),
        .req         ( req         ),
        .rsp         ( rsp         ),
        .gpio_in     ( gpio_in     ),
        .gpio_out    ( gpio_out    ),
        .gpio_oe     ( gpio_oe     ),
        .timer_irq   ( timer_irq   ),
        .boot_addr   ( boot_addr   ),
        .err_count   ( err_count   ),
        .check_count ( check_count )
    );

    // all driving happens 1 ns after a rising edge
    task automatic idle(input int unsigned cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic apb_xfer(input logic [31:0] addr, input logic write, input logic [31:0] data);
        req.paddr   = addr;
        req.pwrite  = write;
        req.pwdata  = data;
        req.psel    = 1'b1;
        req.penable = 1'b0;
        idle(1);
        req.penable = 1'b1;
        idle(1);
        req.psel    = 1'b0;
        req.penable = 1'b0;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        req     = '0;
        gpio_in = '0;
        arst_n  = 1'b0;
        void'($urandom(32'he369));
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle(1);
        // reset values, then the read-only identifier
        apb_xfer(GPIO_BASE, 1'b0, 32'h0);
        apb_xfer(GPIO_BASE + 32'h4, 1'b0, 32'h0);
        apb_xfer(SOCCTRL_BASE + 32'h4, 1'b0, 32'h0);
        apb_xfer(SOCCTRL_BASE, 1'b1, $urandom);
        apb_xfer(SOCCTRL_BASE, 1'b0, 32'h0);
        // park the compare value far above any count this run reaches
        apb_xfer(TMR + 32'h8, 1'b1, 32'hF000_0000);
        for (int n = 0; n < NUM_XFERS; n++) begin
            addr = addr_list[$urandom_range(16, 0)];
            data = $urandom;
            if (addr == TMR + 32'h8) begin
                data = data | 32'h1000_0000;
            end
            apb_xfer(addr, 1'($urandom_range(1, 0)), data);
            if ($urandom_range(7, 0) == 0) begin
                gpio_in = NUM_GPIO'($urandom);
                idle(3);
            end else begin
                idle($urandom_range(3, 0));
            end
        end
        // compare match a few counts after a fresh clear
        apb_xfer(TMR, 1'b1, 32'h0);
        apb_xfer(TMR + 32'h8, 1'b1, 32'd8);
        apb_xfer(TMR, 1'b1, 32'h3);
        idle(IRQ_WAIT);
        apb_xfer(TMR + 32'hC, 1'b0, 32'h0);
        apb_xfer(TMR, 1'b1, 32'h0);
        apb_xfer(TMR + 32'hC, 1'b1, 32'h1);
        apb_xfer(TMR + 32'hC, 1'b0, 32'h0);
        idle(4);
        assert_fails = i_periph_bus_wrap.i_apb_node.i_tb_periph_asserts.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_periph_asserts.sv ====
// APB protocol assertions for the node
`default_nettype none

module tb_periph_asserts
    import apb_soc_pkg::*;
(
    input logic                          clk_i,
    input logic                          arst_n,
    input apb_req_t                      req,
    input apb_rsp_t                      rsp,
    input apb_req_t [NUM_APB_SLAVES-1:0] slv_req,
    input slv_idx_t                      sel_idx_q,
    input logic                          sel_hit_q
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [NUM_APB_SLAVES-1:0] slv_psel;
    int unsigned               fail_count = 0;

    always_comb begin
        for (int i = 0; i < NUM_APB_SLAVES; i++) begin
            slv_psel[i] = slv_req[i].psel;
        end
    end

    // an access cycle is always preceded by its setup cycle
    penable_after_setup: assert property (@(posedge clk_i) disable iff (!arst_n)
        (req.psel && req.penable) |-> $past(req.psel && !req.penable))
        else begin
            fail_count++;
            $error("penable without a preceding setup cycle");
        end

    // in the access phase only the target decoded in setup sees psel
    one_target_selected: assert property (@(posedge clk_i) disable iff (!arst_n)
        (req.psel && req.penable)
            |-> (slv_psel == (sel_hit_q ? (NUM_APB_SLAVES'(1) << sel_idx_q) : '0)))
        else begin
            fail_count++;
            $error("target psel differs from the target decoded in setup");
        end

    response_valid: assert property (@(posedge clk_i) disable iff (!arst_n)
        (req.psel && req.penable && rsp.pready) |-> !$isunknown(rsp))
        else begin
            fail_count++;
            $error("unknown response in the access phase");
        end

    // the error response matches the selection held since setup
    error_follows_decode: assert property (@(posedge clk_i) disable iff (!arst_n)
        (req.psel && req.penable) |-> (rsp.pslverr == !sel_hit_q))
        else begin
            fail_count++;
            $error("pslverr disagrees with the registered decode");
        end

endmodule

bind apb_node tb_periph_asserts i_tb_periph_asserts (
    .clk_i     ( clk_i     ),
    .arst_n    ( arst_n    ),
    .req       ( req       ),
    .rsp       ( rsp       ),
    .slv_req   ( slv_req   ),
    .sel_idx_q ( sel_idx_q ),
    .sel_hit_q ( sel_hit_q )
);

`default_nettype wire

// ==== sim/tb_checker.sv ====
// register map model and checker
`default_nettype none

module tb_checker
    import apb_soc_pkg::*;
#(
    parameter int unsigned NUM_GPIO = 16
) (
    input  logic                clk_i,
    input  logic                arst_n,
    input  apb_req_t            req,
    input  apb_rsp_t            rsp,
    input  logic [NUM_GPIO-1:0] gpio_in,
    input  logic [NUM_GPIO-1:0] gpio_out,
    input  logic [NUM_GPIO-1:0] gpio_oe,
    input  logic                timer_irq,
    input  logic [31:0]         boot_addr,
    output int unsigned         err_count,
    output int unsigned         check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] GPIO_MASK = (NUM_GPIO >= 32) ? '1 : ((32'd1 << NUM_GPIO) - 1);
    // compare values at or above this are never reached by the counter
    localparam logic [31:0] CMP_FAR = 32'h1000_0000;

    logic [31:0] out_m, dir_m, boot_m, scr0_m, scr1_m, cmp_m, cnt_lo, gin_last;
    logic        en_m, cnt_exact, irq_known, irq_val, irq_pending;
    longint      cyc, gin_cyc, irq_due;

    initial begin
        err_count   = 0;
        check_count = 0;
    end

    task automatic flag_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        err_count++;
        $display("MISMATCH %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
    endtask

    function automatic int region_of(input logic [31:0] addr);
        if (addr >= GPIO_BASE && addr < GPIO_BASE + GPIO_LENGTH) return 0;
        if (addr >= ADVTIMER_BASE && addr < ADVTIMER_BASE + ADVTIMER_LENGTH) return 1;
        if (addr >= SOCCTRL_BASE && addr < SOCCTRL_BASE + SOCCTRL_LENGTH) return 2;
        return -1;
    endfunction

    always @(posedge clk_i) begin
        int          region;
        logic [11:0] off;
        logic [31:0] d;
        logic [31:0] exp;
        logic        check_data;
        if (!arst_n) begin
            {out_m, dir_m, scr0_m, scr1_m, cmp_m, cnt_lo} = '0;
            boot_m = BOOT_ADDR_RST;
            {en_m, irq_val, irq_pending} = '0;
            {cnt_exact, irq_known} = 2'b11;
            gin_last = 32'(gpio_in);
            cyc = 0;
            gin_cyc = 0;
        end else begin
            cyc++;
            if (32'(gpio_in) != gin_last) begin
                gin_last = 32'(gpio_in);
                gin_cyc  = cyc;
            end
            if (req.psel && req.penable) begin
                region     = region_of(req.paddr);
                off        = req.paddr[11:0];
                d          = req.pwdata;
                exp        = '0;
                check_data = 1'b1;
                check_count++;
                if (rsp.pready !== 1'b1) begin
                    flag_mismatch("access pready", 32'(rsp.pready), 1);
                end
                if (region < 0) begin
                    if (rsp.pslverr !== 1'b1) flag_mismatch("unmapped pslverr", 32'(rsp.pslverr), 1);
                    if (rsp.prdata !== '0) flag_mismatch("unmapped prdata", rsp.prdata, 0);
                end else if (rsp.pslverr !== 1'b0) begin
                    flag_mismatch("mapped pslverr", 32'(rsp.pslverr), 0);
                end
                if (region >= 0 && !req.pwrite) begin
                    case ({region[1:0], off})
                        {2'd0, 12'h0}: exp = out_m;
                        {2'd0, 12'h4}: exp = dir_m;
                        {2'd0, 12'h8}: begin
                            exp        = gin_last;
                            check_data = (cyc - gin_cyc) >= 2;
                        end
                        {2'd1, 12'h0}: exp = {31'b0, en_m};
                        {2'd1, 12'h4}: begin
                            exp        = cnt_lo;
                            check_data = cnt_exact;
                            if (!cnt_exact && rsp.prdata < cnt_lo) begin
                                flag_mismatch("TMR_CNT went backwards", rsp.prdata, cnt_lo);
                            end
                            cnt_lo = rsp.prdata;
                            cnt_exact = cnt_exact || !en_m;
                        end
                        {2'd1, 12'h8}: exp = cmp_m;
                        {2'd1, 12'hC}: begin
                            exp        = {31'b0, irq_val};
                            check_data = irq_known;
                        end
                        {2'd2, 12'h0}: exp = CHIP_ID;
                        {2'd2, 12'h4}: exp = boot_m;
                        {2'd2, 12'h8}: exp = scr0_m;
                        {2'd2, 12'hC}: exp = scr1_m;
                        default:       exp = '0;
                    endcase
                    if (check_data && rsp.prdata !== exp) begin
                        flag_mismatch($sformatf("read 0x%08h", req.paddr), rsp.prdata, exp);
                    end
                end
                if (region >= 0 && req.pwrite) begin
                    case ({region[1:0], off})
                        {2'd0, 12'h0}: out_m = d & GPIO_MASK;
                        {2'd0, 12'h4}: dir_m = d & GPIO_MASK;
                        {2'd1, 12'h0}: begin
                            cnt_exact = d[1] ? !d[0] : (cnt_exact && !en_m && !d[0]);
                            if (d[1]) cnt_lo = '0;
                            if (d[0] && cmp_m < CMP_FAR) begin
                                irq_known = 1'b0;
                                if (d[1]) begin
                                    irq_pending = 1'b1;
                                    irq_due     = cyc + cmp_m + 2;
                                end
                            end
                            en_m = d[0];
                        end
                        {2'd1, 12'h8}: begin
                            cmp_m = d;
                            if (en_m && d < CMP_FAR) irq_known = 1'b0;
                        end
                        {2'd1, 12'hC}: begin
                            if (d[0] && !irq_pending && (!en_m || cmp_m >= CMP_FAR)) begin
                                irq_known = 1'b1;
                                irq_val   = 1'b0;
                            end
                        end
                        {2'd2, 12'h4}: boot_m = d;
                        {2'd2, 12'h8}: scr0_m = d;
                        {2'd2, 12'hC}: scr1_m = d;
                        default: ;
                    endcase
                end
            end
        end
    end

    // outputs settle after the rising edge, so compare them on the falling one
    always @(negedge clk_i) begin
        if (arst_n) begin
            if (32'(gpio_out) !== out_m) flag_mismatch("gpio_out", 32'(gpio_out), out_m);
            if (32'(gpio_oe) !== dir_m) flag_mismatch("gpio_oe", 32'(gpio_oe), dir_m);
            if (boot_addr !== boot_m) flag_mismatch("boot_addr", boot_addr, boot_m);
            if (irq_pending && cyc >= irq_due) begin
                irq_pending = 1'b0;
                irq_known   = 1'b1;
                irq_val     = 1'b1;
            end
            if (irq_known && timer_irq !== irq_val) begin
                flag_mismatch("timer_irq", 32'(timer_irq), 32'(irq_val));
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/periph_bus_wrap.sv ====
// peripheral bus top level
`default_nettype none

module periph_bus_wrap
    import apb_soc_pkg::*;
#(
    parameter int unsigned NUM_GPIO    = 16,
    parameter int unsigned TIMER_WIDTH = 32
) (
    input  logic                clk_i,
    input  logic                arst_n,
    input  apb_req_t            req,
    output apb_rsp_t            rsp,
    input  logic [NUM_GPIO-1:0] gpio_in,
    output logic [NUM_GPIO-1:0] gpio_out,
    output logic [NUM_GPIO-1:0] gpio_oe,
    output logic                timer_irq,
    output logic [31:0]         boot_addr
);

    apb_req_t [NUM_APB_SLAVES-1:0] slv_req;
    apb_rsp_t [NUM_APB_SLAVES-1:0] slv_rsp;

    apb_node i_apb_node (
        .clk_i   ( clk_i   ),
        .arst_n  ( arst_n  ),
        .req     ( req     ),
        .rsp     ( rsp     ),
        .slv_req ( slv_req ),
        .slv_rsp ( slv_rsp )
    );

    gpio_regs #(
        .NUM_GPIO ( NUM_GPIO )
    ) i_gpio_regs (
        .clk_i    ( clk_i             ),
        .arst_n   ( arst_n            ),
        .req      ( slv_req[GPIO_IDX] ),
        .rsp      ( slv_rsp[GPIO_IDX] ),
        .gpio_in  ( gpio_in           ),
        .gpio_out ( gpio_out          ),
        .gpio_oe  ( gpio_oe           )
    );

    adv_timer #(
        .TIMER_WIDTH ( TIMER_WIDTH )
    ) i_adv_timer (
        .clk_i  ( clk_i                 ),
        .arst_n ( arst_n                ),
        .req    ( slv_req[ADVTIMER_IDX] ),
        .rsp    ( slv_rsp[ADVTIMER_IDX] ),
        .irq    ( timer_irq             )
    );

    soc_ctrl_regs i_soc_ctrl_regs (
        .clk_i     ( clk_i                ),
        .arst_n    ( arst_n               ),
        .req       ( slv_req[SOCCTRL_IDX] ),
        .rsp       ( slv_rsp[SOCCTRL_IDX] ),
        .boot_addr ( boot_addr            )
    );

endmodule

`default_nettype wire

// ==== rtl/soc_ctrl_regs.sv ====
// SoC control registers
`default_nettype none

module soc_ctrl_regs
    import apb_soc_pkg::*;
(
    input  logic        clk_i,
    input  logic        arst_n,
    input  apb_req_t    req,
    output apb_rsp_t    rsp,
    output logic [31:0] boot_addr
);

    logic [31:0] boot_q;
    logic [31:0] scratch0_q;
    logic [31:0] scratch1_q;
    reg_off_t    reg_off;
    logic        wr_en;

    assign reg_off = req.paddr[OFFSET_WIDTH-1:0];
    assign wr_en   = req.psel && req.penable && req.pwrite;

    // SOC_ID has no storage, writes to it fall into the default arm
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            boot_q     <= BOOT_ADDR_RST;
            scratch0_q <= '0;
            scratch1_q <= '0;
        end else if (wr_en) begin
            case (reg_off)
                SOC_BOOT:     boot_q     <= req.pwdata;
                SOC_SCRATCH0: scratch0_q <= req.pwdata;
                SOC_SCRATCH1: scratch1_q <= req.pwdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (reg_off)
            SOC_ID:       rsp.prdata = CHIP_ID;
            SOC_BOOT:     rsp.prdata = boot_q;
            SOC_SCRATCH0: rsp.prdata = scratch0_q;
            SOC_SCRATCH1: rsp.prdata = scratch1_q;
            default:      rsp.prdata = '0;
        endcase
    end

    assign rsp.pready  = req.psel && req.penable;
    assign rsp.pslverr = 1'b0;

    // the boot address goes straight to the core's fetch logic
    assign boot_addr = boot_q;

endmodule

`default_nettype wire

// ==== rtl/adv_timer.sv ====
// compare timer with sticky interrupt
`default_nettype none

module adv_timer
    import apb_soc_pkg::*;
#(
    parameter int unsigned TIMER_WIDTH = 32
) (
    input  logic     clk_i,
    input  logic     arst_n,
    input  apb_req_t req,
    output apb_rsp_t rsp,
    output logic     irq
);

    logic                   en_q;
    logic [TIMER_WIDTH-1:0] cnt_q;
    logic [TIMER_WIDTH-1:0] cmp_q;
    logic                   irq_q;
    reg_off_t               reg_off;
    logic                   wr_en;
    logic                   cnt_clr;
    logic                   irq_clr;
    logic                   cmp_match;

    assign reg_off = req.paddr[OFFSET_WIDTH-1:0];
    assign wr_en   = req.psel && req.penable && req.pwrite;

    assign cnt_clr   = wr_en && (reg_off == TMR_CTRL) && req.pwdata[1];
    assign irq_clr   = wr_en && (reg_off == TMR_IRQ) && req.pwdata[0];
    assign cmp_match = en_q && (cnt_q == cmp_q);

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            en_q  <= 1'b0;
            cmp_q <= '0;
        end else if (wr_en) begin
            case (reg_off)
                TMR_CTRL: en_q  <= req.pwdata[0];
                TMR_CMP:  cmp_q <= req.pwdata[TIMER_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // the counter wraps naturally at its maximum
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            cnt_q <= '0;
        end else if (cnt_clr) begin
            cnt_q <= '0;
        end else if (en_q) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // a match in the same cycle as a clear keeps the flag set
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            irq_q <= 1'b0;
        end else if (cmp_match) begin
            irq_q <= 1'b1;
        end else if (irq_clr) begin
            irq_q <= 1'b0;
        end
    end

    always_comb begin
        case (reg_off)
            TMR_CTRL: rsp.prdata = {31'b0, en_q};
            TMR_CNT:  rsp.prdata = 32'(cnt_q);
            TMR_CMP:  rsp.prdata = 32'(cmp_q);
            TMR_IRQ:  rsp.prdata = {31'b0, irq_q};
            default:  rsp.prdata = '0;
        endcase
    end

    assign rsp.pready  = req.psel && req.penable;
    assign rsp.pslverr = 1'b0;
    assign irq         = irq_q;

endmodule

`default_nettype wire

// ==== rtl/gpio_regs.sv ====
// GPIO register block
`default_nettype none

module gpio_regs
    import apb_soc_pkg::*;
#(
    parameter int unsigned NUM_GPIO = 16
) (
    input  logic                clk_i,
    input  logic                arst_n,
    input  apb_req_t            req,
    output apb_rsp_t            rsp,
    input  logic [NUM_GPIO-1:0] gpio_in,
    output logic [NUM_GPIO-1:0] gpio_out,
    output logic [NUM_GPIO-1:0] gpio_oe
);

    logic [NUM_GPIO-1:0] out_q;
    logic [NUM_GPIO-1:0] dir_q;
    logic [NUM_GPIO-1:0] in_meta_q;
    logic [NUM_GPIO-1:0] in_sync_q;
    reg_off_t            reg_off;
    logic                wr_en;

    assign reg_off = req.paddr[OFFSET_WIDTH-1:0];
    assign wr_en   = req.psel && req.penable && req.pwrite;

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            out_q <= '0;
            dir_q <= '0;
        end else if (wr_en) begin
            case (reg_off)
                GPIO_OUT: out_q <= req.pwdata[NUM_GPIO-1:0];
                GPIO_DIR: dir_q <= req.pwdata[NUM_GPIO-1:0];
                default: ;
            endcase
        end
    end

    // two stage synchronizer for the asynchronous pad inputs
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_in;
            in_sync_q <= in_meta_q;
        end
    end

    always_comb begin
        case (reg_off)
            GPIO_OUT: rsp.prdata = 32'(out_q);
            GPIO_DIR: rsp.prdata = 32'(dir_q);
            GPIO_IN:  rsp.prdata = 32'(in_sync_q);
            default:  rsp.prdata = '0;
        endcase
    end

    // no wait states and no error, unknown offsets just read zero
    assign rsp.pready  = req.psel && req.penable;
    assign rsp.pslverr = 1'b0;

    assign gpio_out = out_q;
    assign gpio_oe  = dir_q;

endmodule

`default_nettype wire

// ==== rtl/apb_node.sv ====
// APB address decoder and response mux
`default_nettype none

module apb_node
    import apb_soc_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                arst_n,
    input  apb_req_t                            req,
    output apb_rsp_t                            rsp,
    output apb_req_t [NUM_APB_SLAVES-1:0]       slv_req,
    input  apb_rsp_t [NUM_APB_SLAVES-1:0]       slv_rsp
);

    // region table, entry i belongs to target index i
    localparam logic [NUM_APB_SLAVES-1:0][31:0] REGION_BASE = {
        SOCCTRL_BASE,
        ADVTIMER_BASE,
        GPIO_BASE
    };
    localparam logic [NUM_APB_SLAVES-1:0][31:0] REGION_LAST = {
        SOCCTRL_BASE + SOCCTRL_LENGTH - 32'd1,
        ADVTIMER_BASE + ADVTIMER_LENGTH - 32'd1,
        GPIO_BASE + GPIO_LENGTH - 32'd1
    };

    logic [NUM_APB_SLAVES-1:0] hit;
    slv_idx_t                  sel_idx;
    logic                      sel_hit;
    slv_idx_t                  sel_idx_q;
    logic                      sel_hit_q;

    always_comb begin
        hit = '0;
        for (int i = 0; i < NUM_APB_SLAVES; i++) begin
            hit[i] = (req.paddr >= REGION_BASE[i]) && (req.paddr <= REGION_LAST[i]);
        end
    end

    // regions do not overlap, so the lowest hit is the only one
    always_comb begin
        sel_idx = '0;
        sel_hit = 1'b0;
        for (int i = NUM_APB_SLAVES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                sel_idx = slv_idx_t'(i);
                sel_hit = 1'b1;
            end
        end
    end

    // every target sees the same request, only psel is steered
    always_comb begin
        for (int i = 0; i < NUM_APB_SLAVES; i++) begin
            slv_req[i]      = req;
            slv_req[i].psel = req.psel && sel_hit && (sel_idx == slv_idx_t'(i));
        end
    end

    always_comb begin
        if (sel_hit) begin
            rsp = slv_rsp[sel_idx];
        end else begin
            // unmapped address, the node answers with an error itself
            rsp.prdata  = '0;
            rsp.pready  = req.psel && req.penable;
            rsp.pslverr = req.psel && req.penable;
        end
    end

    // selection captured in setup and held through the access phase
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            sel_idx_q <= '0;
            sel_hit_q <= 1'b0;
        end else if (req.psel && !req.penable) begin
            sel_idx_q <= sel_idx;
            sel_hit_q <= sel_hit;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/apb_soc_pkg.sv ====
// APB peripheral bus definitions
`default_nettype none

package apb_soc_pkg;

    // request from the requester towards a target
    typedef struct packed {
        logic [31:0] paddr;
        logic        pwrite;
        logic [31:0] pwdata;
        logic        psel;
        logic        penable;
    } apb_req_t;

    // response from a target back to the requester
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    localparam int unsigned NUM_APB_SLAVES = 3;
    localparam int unsigned SLV_IDX_WIDTH  = $clog2(NUM_APB_SLAVES);
    typedef logic [SLV_IDX_WIDTH-1:0] slv_idx_t;

    // target order behind the node
    localparam slv_idx_t GPIO_IDX     = slv_idx_t'(0);
    localparam slv_idx_t ADVTIMER_IDX = slv_idx_t'(1);
    localparam slv_idx_t SOCCTRL_IDX  = slv_idx_t'(2);

    localparam logic [31:0] GPIO_BASE       = 32'h1A10_1000;
    localparam logic [31:0] GPIO_LENGTH     = 32'h0000_1000;
    localparam logic [31:0] ADVTIMER_BASE   = 32'h1A10_2000;
    localparam logic [31:0] ADVTIMER_LENGTH = 32'h0000_1000;
    localparam logic [31:0] SOCCTRL_BASE    = 32'h1A10_4000;
    localparam logic [31:0] SOCCTRL_LENGTH  = 32'h0000_1000;

    // byte offsets inside a 4 KiB region
    localparam int unsigned OFFSET_WIDTH = 12;
    typedef logic [OFFSET_WIDTH-1:0] reg_off_t;

    localparam reg_off_t GPIO_OUT     = 12'h000;
    localparam reg_off_t GPIO_DIR     = 12'h004;
    localparam reg_off_t GPIO_IN      = 12'h008;

    localparam reg_off_t TMR_CTRL     = 12'h000;
    localparam reg_off_t TMR_CNT      = 12'h004;
    localparam reg_off_t TMR_CMP      = 12'h008;
    localparam reg_off_t TMR_IRQ      = 12'h00C;

    localparam reg_off_t SOC_ID       = 12'h000;
    localparam reg_off_t SOC_BOOT     = 12'h004;
    localparam reg_off_t SOC_SCRATCH0 = 12'h008;
    localparam reg_off_t SOC_SCRATCH1 = 12'h00C;

    localparam logic [31:0] CHIP_ID       = 32'h0C0F_FEE1;
    localparam logic [31:0] BOOT_ADDR_RST = 32'h1C00_8080;

endpackage

`default_nettype wire
